// ==== hw/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

    // register byte offsets, decoded from addr[3:0]
    typedef enum logic [3:0] {
        SPI_CTRL   = 4'h0,
        SPI_DATA   = 4'h4,
        SPI_STATUS = 4'h8
    } spi_reg_e;

    // decoded view of the control register
    typedef struct packed {
        logic       start;  // self-clearing go bit
        logic       cpol;   // clock idle level
        logic       cpha;   // 1: drive on leading edge
        logic       sel;    // slave select, active high here
        logic [7:0] div;    // strobe every div+1 cycles
    } spi_ctrl_t;

    // core-side request, no handshake
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } spi_bus_req_t;

    // sequencer outputs toward the serial engine and the registers
    typedef struct packed {
        logic busy;    // frame in progress
        logic strobe;  // one spi clock edge this cycle
        logic odd;     // strobe number is odd (1st, 3rd, ...)
        logic last;    // counter sits on the final strobe
        logic done;    // one cycle after the final strobe
    } spi_edge_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_DONE
    } spi_seq_e;

endpackage

`default_nettype wire

// ==== hw/spi_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_regs (
    input  wire                   clk,
    input  wire                   rst,
    input  wire spi_pkg::spi_bus_req_t bus_i,
    input  wire spi_pkg::spi_edge_t    edge_i,
    input  wire [7:0]             rx_byte_i,
    output spi_pkg::spi_ctrl_t    ctrl_o,
    output logic [7:0]            tx_data_o,
    output logic [31:0]           rdata_o,
    output logic                  spi_ss_o
);
    import spi_pkg::*;

    logic [31:0] ctrl_q;   // full word kept so reads return what was written
    logic [31:0] data_q;
    logic        busy_q;   // status bit 0
    spi_reg_e    reg_sel;

    assign reg_sel = spi_reg_e'(bus_i.addr[3:0]);

    // field view of the control word
    always_comb begin
        ctrl_o.start = ctrl_q[0];
        ctrl_o.cpol  = ctrl_q[1];
        ctrl_o.cpha  = ctrl_q[2];
        ctrl_o.sel   = ctrl_q[3];
        ctrl_o.div   = ctrl_q[15:8];
    end

    assign tx_data_o = data_q[7:0];
    assign spi_ss_o  = ~ctrl_o.sel;  // select pin is active low

    always_ff @(posedge clk) begin
        if (!rst) begin
            ctrl_q <= 32'h0;
            data_q <= 32'h0;
            busy_q <= 1'b0;
        end else begin
            busy_q <= edge_i.busy;  // status lags the sequencer by one cycle
            if (bus_i.we) begin
                case (reg_sel)
                    SPI_CTRL: begin
                        ctrl_q <= bus_i.wdata;
                    end
                    SPI_DATA: begin
                        data_q <= bus_i.wdata;
                    end
                    default: begin
                        // status is read only
                    end
                endcase
            end else begin
                ctrl_q[0] <= 1'b0;  // start lasts a single idle cycle
                // received byte replaces the tx byte at end of frame
                if (edge_i.done) begin
                    data_q <= {24'h0, rx_byte_i};
                end
            end
        end
    end

    // combinational read port
    always_comb begin
        if (!rst) begin
            rdata_o = 32'h0;
        end else begin
            case (reg_sel)
                SPI_CTRL: begin
                    rdata_o = ctrl_q;
                end
                SPI_DATA: begin
                    rdata_o = data_q;
                end
                SPI_STATUS: begin
                    rdata_o = {31'h0, busy_q};
                end
                default: begin
                    rdata_o = 32'h0;  // unmapped offset
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/spi_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_clk_gen #(
    parameter int FRAME_BITS = 8
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire spi_pkg::spi_ctrl_t ctrl_i,
    output spi_pkg::spi_edge_t      edge_o
);
    import spi_pkg::*;

    localparam int LAST_EDGE = 2 * FRAME_BITS;          // index of the final strobe
    localparam int CNT_W     = $clog2(LAST_EDGE + 1);

    spi_seq_e         state;
    spi_seq_e         state_nxt;
    logic [7:0]       div_cnt;
    logic [CNT_W-1:0] edge_cnt;   // strobes already issued in this frame
    logic             strobe;
    logic             at_last;

    assign strobe  = (state == SEQ_RUN) && (div_cnt == ctrl_i.div);
    assign at_last = (edge_cnt == CNT_W'(LAST_EDGE));

    always_comb begin
        state_nxt = state;
        case (state)
            SEQ_IDLE: begin
                if (ctrl_i.start) begin
                    state_nxt = SEQ_RUN;
                end
            end
            SEQ_RUN: begin
                if (strobe && at_last) begin
                    state_nxt = SEQ_DONE;
                end
            end
            SEQ_DONE: begin
                state_nxt = SEQ_IDLE;  // single cycle
            end
            default: begin
                state_nxt = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= SEQ_IDLE;
            div_cnt  <= 8'h0;
            edge_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state != SEQ_RUN) begin
                div_cnt  <= 8'h0;
                edge_cnt <= '0;
            end else if (strobe) begin
                div_cnt  <= 8'h0;  // wrap
                edge_cnt <= edge_cnt + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        edge_o.busy   = (state == SEQ_RUN);
        edge_o.strobe = strobe;
        edge_o.odd    = ~edge_cnt[0];  // count 0 is the first strobe
        edge_o.last   = at_last;
        edge_o.done   = (state == SEQ_DONE);
    end

endmodule

`default_nettype wire

// ==== hw/spi_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_shifter #(
    parameter int FRAME_BITS = 8
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire spi_pkg::spi_ctrl_t ctrl_i,
    input  wire [7:0]               tx_data_i,
    input  wire spi_pkg::spi_edge_t edge_i,
    input  wire                     spi_miso_i,
    output logic                    spi_mosi_o,
    output logic                    spi_clk_o,
    output logic [7:0]              rx_byte_o
);

    localparam int IDX_W = $clog2(FRAME_BITS);

    logic [IDX_W-1:0] bit_idx;      // next tx bit, counts down
    logic [7:0]       rx_sr;
    logic             toggle_edge;  // strobe that moves spi_clk
    logic             drive_edge;
    logic             sample_edge;

    assign toggle_edge = edge_i.strobe && !edge_i.last;

    // cpha 1: drive on odd strobes, sample on even; cpha 0 the other way
    assign drive_edge  = toggle_edge && (edge_i.odd == ctrl_i.cpha);
    assign sample_edge = toggle_edge && (edge_i.odd != ctrl_i.cpha);

    always_ff @(posedge clk) begin
        if (!rst) begin
            spi_clk_o  <= 1'b0;
            spi_mosi_o <= 1'b0;
            bit_idx    <= '0;
        end else if (!edge_i.busy) begin
            spi_clk_o <= ctrl_i.cpol;  // idle level
            if (!ctrl_i.cpha) begin
                // msb must be on the line before the first leading edge
                spi_mosi_o <= tx_data_i[FRAME_BITS-1];
                bit_idx    <= IDX_W'(FRAME_BITS - 2);
            end else begin
                bit_idx <= IDX_W'(FRAME_BITS - 1);
            end
        end else if (edge_i.strobe) begin
            if (edge_i.last) begin
                spi_clk_o <= ctrl_i.cpol;  // park the clock
            end else begin
                spi_clk_o <= ~spi_clk_o;
            end

            // with cpha 0 the final trailing edge drives a don't-care bit
            if (drive_edge) begin
                spi_mosi_o <= tx_data_i[bit_idx];
                bit_idx    <= bit_idx - 1'b1;
            end
        end
    end

    // msb arrives first
    always_ff @(posedge clk) begin
        if (!rst) begin
            rx_sr <= 8'h0;
        end else if (sample_edge) begin
            rx_sr <= {rx_sr[6:0], spi_miso_i};
        end
    end

    assign rx_byte_o = rx_sr;

endmodule

`default_nettype wire

// ==== hw/spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_master #(
    parameter int FRAME_BITS = 8  // bits per transfer
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire spi_pkg::spi_bus_req_t bus_i,
    output logic [31:0]                rdata_o,
    input  wire                        spi_miso_i,
    output logic                       spi_mosi_o,
    output logic                       spi_clk_o,
    output logic                       spi_ss_o
);
    import spi_pkg::*;

    spi_ctrl_t  ctrl;       // decoded control fields
    spi_edge_t  spi_edge;   // sequencer strobes
    logic [7:0] tx_data;
    logic [7:0] rx_byte;

    spi_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .bus_i     (bus_i),
        .edge_i    (spi_edge),
        .rx_byte_i (rx_byte),
        .ctrl_o    (ctrl),
        .tx_data_o (tx_data),
        .rdata_o   (rdata_o),
        .spi_ss_o  (spi_ss_o)
    );

    spi_clk_gen #(
        .FRAME_BITS (FRAME_BITS)
    ) u_clk_gen (
        .clk    (clk),
        .rst    (rst),
        .ctrl_i (ctrl),
        .edge_o (spi_edge)
    );

    spi_shifter #(
        .FRAME_BITS (FRAME_BITS)
    ) u_shifter (
        .clk        (clk),
        .rst        (rst),
        .ctrl_i     (ctrl),
        .tx_data_i  (tx_data),
        .edge_i     (spi_edge),
        .spi_miso_i (spi_miso_i),
        .spi_mosi_o (spi_mosi_o),
        .spi_clk_o  (spi_clk_o),
        .rx_byte_o  (rx_byte)
    );

endmodule

`default_nettype wire

// ==== tb/spi_master_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_master_properties (
    input wire                        clk,
    input wire                        rst,
    input wire spi_pkg::spi_bus_req_t bus_i,
    input wire spi_pkg::spi_ctrl_t    ctrl,
    input wire spi_pkg::spi_edge_t    spi_edge,
    input wire [31:0]                 rdata_o,
    input wire                        spi_clk_o,
    input wire                        spi_ss_o
);
    import spi_pkg::*;

    // clock parks at cpol outside a frame, one cycle of lag after a cpol change
    property clk_idle_at_cpol;
        @(posedge clk) disable iff (!rst)
            (!spi_edge.busy && $stable(ctrl.cpol)) |-> (spi_clk_o == ctrl.cpol);
    endproperty

    // select pin takes the inverted sel bit of each control write
    property ss_follows_sel;
        @(posedge clk) disable iff (!rst)
            (bus_i.we && bus_i.addr[3:0] == 4'h0) |=>
                (spi_ss_o == !$past(bus_i.wdata[3]));
    endproperty

    property ss_holds_without_write;
        @(posedge clk) disable iff (!rst)
            !(bus_i.we && bus_i.addr[3:0] == 4'h0) |=> $stable(spi_ss_o);
    endproperty

    property unmapped_reads_zero;
        @(posedge clk) disable iff (!rst)
            (bus_i.addr[3:0] != 4'h0 && bus_i.addr[3:0] != 4'h4 &&
             bus_i.addr[3:0] != 4'h8) |-> (rdata_o == 32'h0);
    endproperty

    a_clk_idle: assert property (clk_idle_at_cpol)
        else $error("spi_clk_o not at cpol while idle");
    a_ss_sel: assert property (ss_follows_sel)
        else $error("spi_ss_o does not match inverted sel");
    a_ss_hold: assert property (ss_holds_without_write)
        else $error("spi_ss_o changed without a control write");
    a_unmapped: assert property (unmapped_reads_zero)
        else $error("unmapped offset returned nonzero data");

endmodule

bind spi_master spi_master_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .bus_i     (bus_i),
    .ctrl      (ctrl),
    .spi_edge  (spi_edge),
    .rdata_o   (rdata_o),
    .spi_clk_o (spi_clk_o),
    .spi_ss_o  (spi_ss_o)
);

`default_nettype wire

// ==== tb/tb_spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_master;
    import spi_pkg::*;

    logic          clk;
    logic          rst;
    spi_bus_req_t  bus;
    logic [31:0]   rdata;
    logic          spi_miso;
    logic          spi_mosi;
    logic          spi_clk;
    logic          spi_ss;

    int            errors = 0;
    int            tests = 0;
    int            seed = 32'h8ac5_516e;

    // slave model state
    logic          mode_cpol = 1'b0;
    logic          mode_cpha = 1'b0;
    logic [7:0]    slave_byte = 8'h0;
    logic [7:0]    slave_tx = 8'h0;
    logic [7:0]    slave_rx = 8'h0;

    // spi clock monitor
    logic          measuring = 1'b0;
    int            clk_edges = 0;
    time           last_edge_t = 0;
    time           half_t = 100;

    spi_master #(.FRAME_BITS(8)) dut (
        .clk        (clk),
        .rst        (rst),
        .bus_i      (bus),
        .rdata_o    (rdata),
        .spi_miso_i (spi_miso),
        .spi_mosi_o (spi_mosi),
        .spi_clk_o  (spi_clk),
        .spi_ss_o   (spi_ss)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // watchdog, 12 frames of 17 edges at up to 4 cycles each plus margin
    initial begin
        repeat (5000) @(posedge clk);
        $display("simulation timed out");
        $display("tests failed");
        $finish;
    end

    // cpha 0 presents the msb as soon as select drops
    always @(negedge spi_ss) begin
        slave_tx = slave_byte;
        slave_rx = 8'h0;
        if (!mode_cpha) begin
            spi_miso <= #10 slave_tx[7];
            slave_tx = {slave_tx[6:0], 1'b0};
        end
    end

    always @(spi_clk) begin
        if (rst === 1'b1 && spi_ss === 1'b0) begin
            if ((spi_clk != mode_cpol) != mode_cpha) begin
                slave_rx = {slave_rx[6:0], spi_mosi};  // sample edge
            end else begin
                spi_miso <= #10 slave_tx[7];
                slave_tx = {slave_tx[6:0], 1'b0};
            end
        end
    end

    always @(spi_clk) begin
        if (measuring) begin
            if (clk_edges > 0) begin
                assert ($time - last_edge_t == half_t)
                else log_mismatch($sformatf("half period %0t, expected %0t",
                                            $time - last_edge_t, half_t));
            end
            clk_edges++;
            last_edge_t = $time;
        end
    end

    task automatic log_mismatch(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [31:0] ctrl_word(input logic [7:0] div, input logic sel,
                                              input logic cpha, input logic cpol,
                                              input logic start);
        ctrl_word = {16'h0, div, 4'h0, sel, cpha, cpol, start};
    endfunction

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        #10;
        bus.addr  = {28'h0, addr};
        bus.wdata = data;
        bus.we    = 1'b1;
        @(posedge clk);  // write edge
        #10;
        bus.we    = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
        bus.addr = {28'h0, addr};
        #1;
        data = rdata;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("test %-12s %0d errors", name, errors - errs_before);
    endtask

    // one frame with full checking, optional second start mid frame
    task automatic run_transfer(input logic cpol, input logic cpha, input logic [7:0] div,
                                input logic restart);
        logic [7:0]  host;
        logic [31:0] rd;
        int          k;
        int          expect_len;
        bit          finished;

        host       = 8'($random(seed));
        slave_byte = 8'($random(seed));
        mode_cpol  = cpol;
        mode_cpha  = cpha;
        half_t     = time'(div + 1) * 100;
        expect_len = 17 * (int'(div) + 1) + 2;
        bus_write(SPI_DATA, {24'h0, host});
        bus_write(SPI_CTRL, ctrl_word(div, 1'b0, cpha, cpol, 1'b0));
        repeat (2) @(posedge clk);
        assert (spi_clk == cpol) else log_mismatch("spi_clk not at cpol before frame");
        clk_edges = 0;
        measuring = 1'b1;
        bus_write(SPI_CTRL, ctrl_word(div, 1'b1, cpha, cpol, 1'b1));
        assert (spi_ss == 1'b0) else log_mismatch("spi_ss not low after select write");
        k = 0;
        finished = 0;
        while (!finished && k < 2000) begin
            @(posedge clk);
            #10;
            k++;
            if (restart && k == 10) begin
                bus.addr  = {28'h0, SPI_CTRL};
                bus.wdata = ctrl_word(div, 1'b1, cpha, cpol, 1'b1);
                bus.we    = 1'b1;
            end else begin
                bus.we = 1'b0;
                bus_read(SPI_STATUS, rd);
                if (k == 2) begin
                    assert (rd[0] == 1'b1) else log_mismatch("busy not set 2 cycles after start");
                end
                if (k >= 2 && rd[0] == 1'b0) begin
                    finished = 1;
                end
            end
        end
        measuring = 1'b0;
        if (!finished) begin
            $display("transfer never finished at time %0t", $time);
            errors++;
        end
        assert (k >= expect_len - 1 && k <= expect_len + 1)
        else log_mismatch($sformatf("frame took %0d cycles, expected %0d", k, expect_len));
        assert (clk_edges == 16) else log_mismatch($sformatf("%0d spi_clk edges", clk_edges));
        assert (spi_clk == cpol) else log_mismatch("spi_clk not at cpol after frame");
        assert (slave_rx == host)
        else log_mismatch($sformatf("slave got %h, expected %h", slave_rx, host));
        bus_read(SPI_DATA, rd);
        assert (rd == {24'h0, slave_byte})
        else log_mismatch($sformatf("data reg %h, expected %h", rd, slave_byte));
        repeat (2) @(posedge clk);  // no second frame may follow
        #10;
        bus_read(SPI_STATUS, rd);
        assert (rd == 32'h0) else log_mismatch("status busy still set");
        bus_write(SPI_CTRL, ctrl_word(div, 1'b0, cpha, cpol, 1'b0));
        assert (spi_ss == 1'b1) else log_mismatch("spi_ss not high after deselect");
    endtask

    initial begin
        logic [31:0] rd;
        int          errs;
        int          n;

        rst       = 1'b0;
        bus.addr  = 32'h0;
        bus.wdata = 32'h0;
        bus.we    = 1'b0;
        spi_miso  = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b1;

        errs = errors;
        bus_read(SPI_CTRL, rd);
        assert (rd == 32'h0) else log_mismatch("control not zero after reset");
        bus_read(SPI_DATA, rd);
        assert (rd == 32'h0) else log_mismatch("data not zero after reset");
        bus_read(SPI_STATUS, rd);
        assert (rd == 32'h0) else log_mismatch("status not zero after reset");
        assert (spi_ss == 1'b1 && spi_clk == 1'b0) else log_mismatch("pins wrong after reset");
        finish_test("reset", errs);

        errs = errors;
        bus_write(SPI_CTRL, 32'h1234_5A0A);  // start clear, upper bits kept
        bus_read(SPI_CTRL, rd);
        assert (rd == 32'h1234_5A0A) else log_mismatch($sformatf("control read %h", rd));
        bus_write(SPI_DATA, 32'hDEAD_BEEF);
        bus_read(SPI_DATA, rd);
        assert (rd == 32'hDEAD_BEEF) else log_mismatch($sformatf("data read %h", rd));
        bus_write(SPI_CTRL, ctrl_word(8'h1, 1'b0, 1'b0, 1'b0, 1'b1));
        @(posedge clk);
        #10;
        bus_read(SPI_CTRL, rd);
        assert (rd[0] == 1'b0) else log_mismatch("start bit did not clear");
        bus_read(4'hC, rd);
        assert (rd == 32'h0) else log_mismatch("offset 0xc not zero");
        n = 0;
        do begin  // let the unselected frame drain
            @(posedge clk);
            #10;
            n++;
            bus_read(SPI_STATUS, rd);
        end while (rd[0] && n < 100);
        finish_test("registers", errs);

        errs = errors;
        for (int m = 0; m < 4; m++) begin
            run_transfer(m[1], m[0], 8'd1, 1'b0);
        end
        finish_test("modes", errs);

        errs = errors;
        run_transfer(1'b0, 1'b0, 8'd0, 1'b0);
        run_transfer(1'b1, 1'b1, 8'd1, 1'b0);
        run_transfer(1'b1, 1'b0, 8'd3, 1'b0);
        finish_test("clock_shape", errs);

        errs = errors;
        run_transfer(1'b0, 1'b1, 8'd1, 1'b1);
        finish_test("busy_select", errs);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== spi_master.f ====
hw/spi_pkg.sv
hw/spi_regs.sv
hw/spi_clk_gen.sv
hw/spi_shifter.sv
hw/spi_master.sv
tb/spi_master_properties.sv
tb/tb_spi_master.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the spi_master testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_spi_master \
    -f spi_master.f \
    -o sim_tb_spi_master
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb_spi_master)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" <<< "$output"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
